/* all.f */
+incdir+verif
common/led_status_pkg.sv
verilog/alert_blinker.sv
verilog/timer_bounce.sv
verilog/led_pattern_select.sv
verilog/led_status_top.sv
verif/tb_led_status.sv

/* common/led_status_pkg.sv */
package led_status_pkg;

    typedef logic [6:0] led_t;  // Lane 6 is the leftmost LED

    typedef enum logic [3:0] {
        INITIAL        = 4'd0,
        CLOCK          = 4'd1,
        SHOW_CLOCK     = 4'd2,
        CHANGE_MODE    = 4'd3,
        TIMER          = 4'd4,
        SHOW_TIMER     = 4'd5,
        ALARM          = 4'd6,
        SHOW_ALARM     = 4'd7,
        SHOW_STOPWATCH = 4'd8
    } ui_state_t;

    typedef logic [2:0] weekday_t;  // 0 is Sunday
    typedef logic [1:0] rec_count_t;
    typedef logic [1:0] rec_sel_t;  // 3 means nothing selected
    typedef logic [3:0] alarm_count_t;
    typedef logic [35:0] timer_count_t;

    localparam led_t ALARM_LANES = 7'b1010101;
    localparam led_t TIMER_LANES = 7'b0101010;

    localparam int BLINK_TOGGLES = 6;

    // Bar pattern for 0 to 10 alarms set
    localparam led_t ALARM_BAR [0:10] = '{
        7'b0000000,
        7'b0000001,
        7'b0000011,
        7'b0000101,
        7'b0000111,
        7'b0010101,
        7'b0010111,
        7'b1010101,
        7'b1010111,
        7'b1011111,
        7'b1111111
    };

    function automatic led_t alarm_bar(input alarm_count_t cnt);
        led_t pattern;
        pattern = '0;  // Counts above 10 show nothing
        if (cnt <= 4'd10) begin
            pattern = ALARM_BAR[cnt];
        end
        return pattern;
    endfunction

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the LED status testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f all.f --top-module tb_led_status \
    -Mdir obj_dir -o tb_led_status
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_led_status > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation passed"
exit 0

/* verif/tb_led_checks.svh */
`ifndef TB_LED_CHECKS_SVH
`define TB_LED_CHECKS_SVH

int led_errors = 0;
int flag_errors = 0;
int other_errors = 0;

task automatic check_led(input string name, input led_status_pkg::led_t expected,
                         input led_status_pkg::led_t actual);
    if (actual !== expected) begin
        led_errors++;
        $display("MISMATCH time %0t signal %s expected %b actual %b",
                 $time, name, expected, actual);
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        flag_errors++;
        $display("MISMATCH time %0t signal %s expected %b actual %b",
                 $time, name, expected, actual);
    end
endtask

// Failures that are not a wrong value on one signal
task automatic report_failure(input string what);
    other_errors++;
    $display("ERROR at time %0t: %s", $time, what);
endtask

`endif

/* verif/tb_led_status.sv */
`timescale 1ns/10ps

module tb_led_status;

    localparam int TICK_PERIOD = 8;
    localparam int ALERT_LIMIT = 70;
    localparam int BOUNCE_CYCLES = 120;
    localparam int FREEZE_CYCLES = 30;
    localparam int RANDOM_CYCLES = 4000;
    localparam int TOTAL_CYCLES = 5 + 40 + 80 + 2 * (ALERT_LIMIT + 3) +
                                  4 * (1 + BOUNCE_CYCLES + FREEZE_CYCLES) + 80 + RANDOM_CYCLES;
    localparam led_status_pkg::led_t BAR_REF [0:10] = '{
        7'h00, 7'h01, 7'h03, 7'h05, 7'h07, 7'h15, 7'h17, 7'h55, 7'h57, 7'h5f, 7'h7f
    };

    logic                         clk = 1'b0;
    logic                         rst;
    led_status_pkg::ui_state_t    state;
    logic                         enter_flag;
    logic                         timer_resume;
    logic                         alarm_match;
    logic                         timer_match;
    led_status_pkg::weekday_t     week;
    led_status_pkg::alarm_count_t alarm_set_cnt;
    led_status_pkg::rec_count_t   timer_rec_tot;
    led_status_pkg::rec_count_t   stopw_rec_tot;
    led_status_pkg::rec_sel_t     timer_chosen;
    led_status_pkg::rec_sel_t     stopw_chosen;
    led_status_pkg::timer_count_t timer_cnt;
    led_status_pkg::led_t         led;
    logic                         blink_alarm;
    logic                         blink_timer;

    // Reference model state
    int                           a_tick;
    int                           a_tog;
    logic                         a_blink;
    int                           t_tick;
    int                           t_tog;
    logic                         t_blink;
    int                           b_tick;
    logic                         m_dir;  // High while the runner heads down
    led_status_pkg::led_t         m_led;
    led_status_pkg::ui_state_t    m_prev;
    logic [31:0]                  lfsr_state;

    `include "tb_led_checks.svh"

    led_status_top #(.TICK_PERIOD(TICK_PERIOD)) dut0 (
        .clk(clk), .rst(rst), .state(state), .enter_flag(enter_flag),
        .timer_resume(timer_resume), .alarm_match(alarm_match), .timer_match(timer_match),
        .week(week), .alarm_set_cnt(alarm_set_cnt), .timer_rec_tot(timer_rec_tot),
        .stopw_rec_tot(stopw_rec_tot), .timer_chosen(timer_chosen),
        .stopw_chosen(stopw_chosen), .timer_cnt(timer_cnt), .led(led),
        .blink_alarm(blink_alarm), .blink_timer(blink_timer)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'ha3000000) : (lfsr_state >> 1);
        end
        return val;
    endfunction

    function automatic led_status_pkg::timer_count_t random_count();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = rand_bits(4);
        lo = rand_bits(32);
        return {hi[3:0], lo};
    endfunction

    function automatic led_status_pkg::led_t week_pattern(input led_status_pkg::weekday_t day);
        led_status_pkg::led_t pat;
        pat = '0;
        if (day == 3'd0) begin
            pat = 7'b1000000;
        end else if (day != 3'd7) begin
            pat = 7'd1 << (day - 3'd1);
        end
        return pat;
    endfunction

    task automatic model_reset();
        a_tick = 0;
        a_tog = 0;
        a_blink = 1'b0;
        t_tick = 0;
        t_tog = 0;
        t_blink = 1'b0;
        b_tick = 0;
        m_dir = 1'b0;
        m_led = '0;
        m_prev = led_status_pkg::INITIAL;
    endtask

    task automatic blinker_update(input logic match, input logic hit, inout int tick,
                                  inout int tog, inout logic blink);
        if (match) begin
            blink = 1'b1;
            tog = 0;
            tick = 1;  // The match cycle is the first tick
        end else if (hit) begin
            tick = 0;
            if (tog == led_status_pkg::BLINK_TOGGLES - 1) begin
                blink = 1'b0;
                tog = 0;
            end else begin
                tog++;
            end
        end else if (blink) begin
            tick++;
        end else begin
            tick = 0;
        end
    endtask

    task automatic model_step();
        logic                 a_hit;
        logic                 t_hit;
        logic                 stepping;
        logic                 ndir;
        logic                 load;
        logic                 home;
        logic                 left_show;
        int                   k;
        int                   run;
        int                   nrun;
        led_status_pkg::led_t solid;
        led_status_pkg::led_t bled;
        led_status_pkg::led_t nled;

        a_hit = a_blink && !alarm_match && (a_tick == TICK_PERIOD - 1);
        t_hit = t_blink && !timer_match && (t_tick == TICK_PERIOD - 1);
        stepping = timer_resume && (b_tick == TICK_PERIOD - 1);

        k = int'(timer_rec_tot);
        solid = (7'd1 << k) - 7'd1;
        run = -1;
        for (int i = 6; i >= k; i--) begin
            if (run < 0 && ((m_led >> i) & 7'd1) != 7'd0) begin
                run = i;
            end
        end
        ndir = m_dir;
        if (run < 0) begin
            nrun = k;
            ndir = 1'b0;
        end else if (run == k) begin
            nrun = k + 1;
            ndir = 1'b0;
        end else if (run == 6) begin
            nrun = 5;
            ndir = 1'b1;
        end else begin
            nrun = m_dir ? run - 1 : run + 1;
        end
        if (timer_cnt == '0) begin
            bled = m_led;
            ndir = m_dir;
        end else begin
            bled = solid | (7'd1 << nrun);
        end

        left_show = (state != m_prev) && (m_prev == led_status_pkg::SHOW_TIMER ||
                    m_prev == led_status_pkg::SHOW_STOPWATCH ||
                    m_prev == led_status_pkg::SHOW_ALARM || m_prev == led_status_pkg::SHOW_CLOCK);
        nled = m_led;
        load = 1'b0;
        home = 1'b1;
        if ((alarm_match || timer_match) && state > led_status_pkg::CLOCK) begin
            nled = '0;
            if (alarm_match) nled = nled | led_status_pkg::ALARM_LANES;
            if (timer_match) nled = nled | led_status_pkg::TIMER_LANES;
        end else if ((a_blink || t_blink) && state > led_status_pkg::CLOCK) begin
            if (a_hit) nled = nled ^ led_status_pkg::ALARM_LANES;
            if (t_hit) nled = nled ^ led_status_pkg::TIMER_LANES;
        end else if (state == led_status_pkg::CHANGE_MODE) begin
            nled = '0;
        end else if (state == led_status_pkg::SHOW_CLOCK) begin
            nled = week_pattern(week);
        end else if (state == led_status_pkg::TIMER && enter_flag) begin
            nled = (7'd1 << (k + 1)) - 7'd1;
        end else if (state == led_status_pkg::ALARM) begin
            nled = (alarm_set_cnt <= 4'd10) ? BAR_REF[alarm_set_cnt] : '0;
        end else begin
            home = 1'b0;
            if (state == led_status_pkg::SHOW_TIMER && !timer_resume) begin
                nled = (timer_chosen != 2'd3) ? 7'd1 << timer_chosen : solid;
            end else if (state == led_status_pkg::SHOW_TIMER && stepping) begin
                nled = bled;
                load = 1'b1;
            end else if (state == led_status_pkg::SHOW_STOPWATCH) begin
                nled = (stopw_chosen != 2'd3) ? 7'b1000000 >> stopw_chosen :
                       ~(7'h7f >> stopw_rec_tot);
            end else if (state == led_status_pkg::SHOW_ALARM) begin
                nled = (alarm_set_cnt <= 4'd10) ? BAR_REF[alarm_set_cnt] : '0;
            end else if (left_show) begin
                nled = '0;
                home = 1'b1;
            end
        end

        if (rst) begin
            model_reset();
        end else begin
            blinker_update(alarm_match, a_hit, a_tick, a_tog, a_blink);
            blinker_update(timer_match, t_hit, t_tick, t_tog, t_blink);
            if (timer_resume) b_tick = stepping ? 0 : b_tick + 1;
            if (home) m_dir = 1'b0;
            else if (load) m_dir = ndir;
            m_led = nled;
            m_prev = state;
        end
    endtask

    task automatic run_cycle();
        @(posedge clk);
        model_step();
        #1;
        check_led("led", m_led, led);
        check_flag("blink_alarm", a_blink, blink_alarm);
        check_flag("blink_timer", t_blink, blink_timer);
    endtask

    task automatic alert_run(input logic timer_side);
        int waited;
        waited = 0;
        state = led_status_pkg::SHOW_ALARM;
        alarm_match = !timer_side;
        timer_match = timer_side;
        run_cycle();
        alarm_match = 1'b0;
        timer_match = 1'b0;
        while ((timer_side ? blink_timer : blink_alarm) && waited < ALERT_LIMIT) begin
            run_cycle();
            waited++;
        end
        if (timer_side ? blink_timer : blink_alarm) begin
            report_failure("the alert kept blinking past the cycle limit");
        end
        run_cycle();
    endtask

    task automatic random_cycle();
        if (rand_bits(4) == 0) begin
            state = led_status_pkg::ui_state_t'(4'(rand_bits(4) % 9));
            timer_rec_tot = 2'(rand_bits(2));
            stopw_rec_tot = 2'(rand_bits(2));
            timer_chosen = 2'(rand_bits(2));
            stopw_chosen = 2'(rand_bits(2));
        end
        rst = rand_bits(9) == 0;
        alarm_match = rand_bits(6) == 0;
        timer_match = rand_bits(6) == 0;
        enter_flag = rand_bits(1) != 0;
        timer_resume = rand_bits(3) != 0;
        week = 3'(rand_bits(3));
        alarm_set_cnt = 4'(rand_bits(4));
        timer_cnt = (rand_bits(3) == 0) ? '0 : random_count();
        run_cycle();
    endtask

    initial begin
        #(TOTAL_CYCLES * 10 + 1000);
        $display("Timeout: the test phases did not complete in the expected time");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [2:0] pick;
        lfsr_state = 32'h65bb849d;
        rst = 1'b1;
        state = led_status_pkg::INITIAL;
        enter_flag = 1'b0;
        timer_resume = 1'b0;
        alarm_match = 1'b0;
        timer_match = 1'b0;
        week = '0;
        alarm_set_cnt = '0;
        timer_rec_tot = '0;
        stopw_rec_tot = '0;
        timer_chosen = 2'd3;
        stopw_chosen = 2'd3;
        timer_cnt = '0;
        model_reset();
        repeat (5) run_cycle();
        rst = 1'b0;
        check_led("led", '0, led);
        check_flag("blink_alarm", 1'b0, blink_alarm);
        check_flag("blink_timer", 1'b0, blink_timer);

        state = led_status_pkg::SHOW_CLOCK;
        repeat (40) begin
            week = 3'(rand_bits(3) % 7);
            run_cycle();
        end

        enter_flag = 1'b1;
        repeat (80) begin
            pick = 3'(rand_bits(2));
            state = (pick == 3'd0) ? led_status_pkg::ALARM :
                    (pick == 3'd1) ? led_status_pkg::SHOW_ALARM : led_status_pkg::TIMER;
            alarm_set_cnt = 4'(rand_bits(4));
            timer_rec_tot = 2'(rand_bits(2));
            run_cycle();
        end

        alert_run(1'b0);
        alert_run(1'b1);

        for (int k = 0; k < 4; k++) begin
            state = led_status_pkg::CHANGE_MODE;
            timer_resume = 1'b0;
            run_cycle();
            state = led_status_pkg::SHOW_TIMER;
            timer_resume = 1'b1;
            timer_rec_tot = 2'(k);
            timer_cnt = random_count() | 36'd1;
            repeat (BOUNCE_CYCLES) run_cycle();
            timer_cnt = '0;  // Countdown done so the runner stops
            repeat (FREEZE_CYCLES) run_cycle();
        end

        timer_resume = 1'b0;
        repeat (80) begin
            pick = 3'(rand_bits(3));
            case (pick)
                3'd0, 3'd1, 3'd2: state = led_status_pkg::SHOW_STOPWATCH;
                3'd3, 3'd4: state = led_status_pkg::SHOW_TIMER;
                3'd5: state = led_status_pkg::CLOCK;
                3'd6: state = led_status_pkg::INITIAL;
                default: state = led_status_pkg::CHANGE_MODE;
            endcase
            timer_rec_tot = 2'(rand_bits(2));
            stopw_rec_tot = 2'(rand_bits(2));
            timer_chosen = 2'(rand_bits(2));
            stopw_chosen = 2'(rand_bits(2));
            run_cycle();
        end

        repeat (RANDOM_CYCLES) random_cycle();

        $display("Error counts: led %0d, flag %0d, other %0d",
                 led_errors, flag_errors, other_errors);
        if (led_errors + flag_errors + other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verilog/alert_blinker.sv */
`timescale 1ns/10ps

module alert_blinker #(
    parameter int TICK_PERIOD = 100000000
) (
    input  logic clk,
    input  logic rst,
    input  logic match,
    output logic blinking,
    output logic toggle
);

    localparam int TICK_W = $clog2(TICK_PERIOD + 1);
    localparam int TOG_W = $clog2(led_status_pkg::BLINK_TOGGLES + 1);

    logic [TICK_W-1:0] tick_cnt;
    logic [TOG_W-1:0]  tog_cnt;
    logic              tick_done;

    assign tick_done = (tick_cnt == TICK_W'(TICK_PERIOD - 1));
    assign toggle = blinking && !match && tick_done;  // A fresh match restarts the period

    always_ff @(posedge clk) begin
        if (rst) begin
            tick_cnt <= '0;
        end else if (match) begin
            tick_cnt <= TICK_W'(1);  // The match cycle counts as the first one
        end else if (blinking) begin
            tick_cnt <= tick_done ? '0 : tick_cnt + 1'b1;
        end else begin
            tick_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            blinking <= 1'b0;
            tog_cnt <= '0;
        end else if (match) begin
            blinking <= 1'b1;
            tog_cnt <= '0;
        end else if (toggle) begin
            if (tog_cnt == TOG_W'(led_status_pkg::BLINK_TOGGLES - 1)) begin
                blinking <= 1'b0;  // Last toggle ends the alert
                tog_cnt <= '0;
            end else begin
                tog_cnt <= tog_cnt + 1'b1;
            end
        end
    end

endmodule

/* verilog/led_pattern_select.sv */
`timescale 1ns/10ps

module led_pattern_select (
    input  logic                         clk,
    input  logic                         rst,
    input  led_status_pkg::ui_state_t    state,
    input  logic                         enter_flag,
    input  logic                         timer_resume,
    input  logic                         alarm_match,
    input  logic                         timer_match,
    input  led_status_pkg::weekday_t     week,
    input  led_status_pkg::alarm_count_t alarm_set_cnt,
    input  led_status_pkg::rec_count_t   timer_rec_tot,
    input  led_status_pkg::rec_count_t   stopw_rec_tot,
    input  led_status_pkg::rec_sel_t     timer_chosen,
    input  led_status_pkg::rec_sel_t     stopw_chosen,
    input  logic                         blink_alarm,
    input  logic                         blink_timer,
    input  logic                         alarm_toggle,
    input  logic                         timer_toggle,
    input  led_status_pkg::led_t         bounce_led,
    input  logic                         step,
    output led_status_pkg::led_t         led,
    output logic                         bounce_load,
    output logic                         bounce_home
);

    led_status_pkg::ui_state_t prev_state;
    led_status_pkg::led_t      next_led;
    led_status_pkg::led_t      week_led;
    led_status_pkg::led_t      timer_bar;
    led_status_pkg::led_t      timer_pick;
    led_status_pkg::led_t      stopw_pick;
    led_status_pkg::led_t      alarm_led;
    led_status_pkg::led_t      blink_mask;
    logic                      display_page;
    logic                      left_show;

    assign display_page = (state > led_status_pkg::CLOCK);

    always_comb begin
        if (week == 3'd0) begin
            week_led = 7'b1000000;  // Sunday sits on the left
        end else if (week == 3'd7) begin
            week_led = '0;
        end else begin
            week_led = led_status_pkg::led_t'(1) << (week - 3'd1);
        end
    end

    assign timer_bar = led_status_pkg::led_t'((7'd2 << timer_rec_tot) - 7'd1);
    assign timer_pick = (timer_chosen != 2'd3) ?
                        led_status_pkg::led_t'(1) << timer_chosen :
                        led_status_pkg::led_t'((7'd1 << timer_rec_tot) - 7'd1);
    // Stopwatch records fill from the left
    assign stopw_pick = (stopw_chosen != 2'd3) ?
                        7'b1000000 >> stopw_chosen :
                        led_status_pkg::led_t'(7'b1110000 << (2'd3 - stopw_rec_tot));
    assign alarm_led = led_status_pkg::alarm_bar(alarm_set_cnt);

    assign blink_mask = (alarm_toggle ? led_status_pkg::ALARM_LANES : '0) |
                        (timer_toggle ? led_status_pkg::TIMER_LANES : '0);

    assign left_show = (state != prev_state) &&
                       (prev_state == led_status_pkg::SHOW_TIMER ||
                        prev_state == led_status_pkg::SHOW_STOPWATCH ||
                        prev_state == led_status_pkg::SHOW_ALARM ||
                        prev_state == led_status_pkg::SHOW_CLOCK);

    always_comb begin
        next_led = led;
        bounce_load = 1'b0;
        bounce_home = 1'b0;
        if ((alarm_match || timer_match) && display_page) begin
            next_led = (alarm_match ? led_status_pkg::ALARM_LANES : '0) |
                       (timer_match ? led_status_pkg::TIMER_LANES : '0);
            bounce_home = 1'b1;
        end else if ((blink_alarm || blink_timer) && display_page) begin
            next_led = led ^ blink_mask;
            bounce_home = 1'b1;
        end else if (state == led_status_pkg::CHANGE_MODE) begin
            next_led = '0;
            bounce_home = 1'b1;
        end else if (state == led_status_pkg::SHOW_CLOCK) begin
            next_led = week_led;
            bounce_home = 1'b1;
        end else if (state == led_status_pkg::TIMER && enter_flag) begin
            next_led = timer_bar;
            bounce_home = 1'b1;
        end else if (state == led_status_pkg::ALARM) begin
            next_led = alarm_led;
            bounce_home = 1'b1;
        end else if (state == led_status_pkg::SHOW_TIMER && !timer_resume) begin
            next_led = timer_pick;  // Direction is kept for the resume
        end else if (state == led_status_pkg::SHOW_TIMER && step) begin
            next_led = bounce_led;
            bounce_load = 1'b1;
        end else if (state == led_status_pkg::SHOW_STOPWATCH) begin
            next_led = stopw_pick;
        end else if (state == led_status_pkg::SHOW_ALARM) begin
            next_led = alarm_led;
        end else if (left_show) begin
            next_led = '0;
            bounce_home = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
            prev_state <= led_status_pkg::INITIAL;
        end else begin
            led <= next_led;
            prev_state <= state;
        end
    end

endmodule

/* verilog/led_status_top.sv */
`timescale 1ns/10ps

module led_status_top #(
    parameter int TICK_PERIOD = 100000000
) (
    input  logic                         clk,
    input  logic                         rst,
    input  led_status_pkg::ui_state_t    state,
    input  logic                         enter_flag,
    input  logic                         timer_resume,
    input  logic                         alarm_match,
    input  logic                         timer_match,
    input  led_status_pkg::weekday_t     week,
    input  led_status_pkg::alarm_count_t alarm_set_cnt,
    input  led_status_pkg::rec_count_t   timer_rec_tot,
    input  led_status_pkg::rec_count_t   stopw_rec_tot,
    input  led_status_pkg::rec_sel_t     timer_chosen,
    input  led_status_pkg::rec_sel_t     stopw_chosen,
    input  led_status_pkg::timer_count_t timer_cnt,
    output led_status_pkg::led_t         led,
    output logic                         blink_alarm,
    output logic                         blink_timer
);

    logic                 alarm_toggle;
    logic                 timer_toggle;
    logic                 step;
    logic                 bounce_load;
    logic                 bounce_home;
    led_status_pkg::led_t bounce_led;

    alert_blinker #(
        .TICK_PERIOD(TICK_PERIOD)
    ) u_alarm_blink (
        .clk     (clk),
        .rst     (rst),
        .match   (alarm_match),
        .blinking(blink_alarm),
        .toggle  (alarm_toggle)
    );

    alert_blinker #(
        .TICK_PERIOD(TICK_PERIOD)
    ) u_timer_blink (
        .clk     (clk),
        .rst     (rst),
        .match   (timer_match),
        .blinking(blink_timer),
        .toggle  (timer_toggle)
    );

    timer_bounce #(
        .TICK_PERIOD(TICK_PERIOD)
    ) u_bounce (
        .clk          (clk),
        .rst          (rst),
        .timer_resume (timer_resume),
        .timer_cnt    (timer_cnt),
        .timer_rec_tot(timer_rec_tot),
        .led          (led),
        .bounce_load  (bounce_load),
        .bounce_home  (bounce_home),
        .bounce_led   (bounce_led),
        .step         (step)
    );

    led_pattern_select u_select (
        .clk          (clk),
        .rst          (rst),
        .state        (state),
        .enter_flag   (enter_flag),
        .timer_resume (timer_resume),
        .alarm_match  (alarm_match),
        .timer_match  (timer_match),
        .week         (week),
        .alarm_set_cnt(alarm_set_cnt),
        .timer_rec_tot(timer_rec_tot),
        .stopw_rec_tot(stopw_rec_tot),
        .timer_chosen (timer_chosen),
        .stopw_chosen (stopw_chosen),
        .blink_alarm  (blink_alarm),
        .blink_timer  (blink_timer),
        .alarm_toggle (alarm_toggle),
        .timer_toggle (timer_toggle),
        .bounce_led   (bounce_led),
        .step         (step),
        .led          (led),
        .bounce_load  (bounce_load),
        .bounce_home  (bounce_home)
    );

endmodule

/* verilog/timer_bounce.sv */
`timescale 1ns/10ps

module timer_bounce #(
    parameter int TICK_PERIOD = 100000000
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         timer_resume,
    input  led_status_pkg::timer_count_t timer_cnt,
    input  led_status_pkg::rec_count_t   timer_rec_tot,
    input  led_status_pkg::led_t         led,
    input  logic                         bounce_load,
    input  logic                         bounce_home,
    output led_status_pkg::led_t         bounce_led,
    output logic                         step
);

    localparam int TICK_W = $clog2(TICK_PERIOD + 1);

    logic [TICK_W-1:0]    tick_cnt;
    logic                 dir;  // Set while the runner travels down towards the records
    logic                 next_dir;
    led_status_pkg::led_t solid;
    led_status_pkg::led_t upper;
    logic [2:0]           low_lane;
    logic [2:0]           runner;
    logic [2:0]           next_runner;

    assign step = timer_resume && (tick_cnt == TICK_W'(TICK_PERIOD - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            tick_cnt <= '0;
        end else if (timer_resume) begin
            tick_cnt <= step ? '0 : tick_cnt + 1'b1;
        end
    end

    // Record lanes stay lit below the runner's range
    assign low_lane = {1'b0, timer_rec_tot};
    assign solid = led_status_pkg::led_t'((7'd1 << timer_rec_tot) - 7'd1);
    assign upper = led & ~solid;

    always_comb begin
        runner = low_lane;
        for (int i = 0; i < 7; i++) begin
            if (upper[i]) begin
                runner = 3'(i);
            end
        end
    end

    always_comb begin
        next_runner = runner;
        next_dir = dir;
        if (upper == '0) begin
            next_runner = low_lane;  // No runner yet so it enters at the bottom
            next_dir = 1'b0;
        end else if (runner == low_lane) begin
            next_runner = low_lane + 3'd1;
            next_dir = 1'b0;
        end else if (runner == 3'd6) begin
            next_runner = 3'd5;
            next_dir = 1'b1;
        end else if (dir) begin
            next_runner = runner - 3'd1;
        end else begin
            next_runner = runner + 3'd1;
        end

        if (timer_cnt == '0) begin
            bounce_led = led;  // Frozen once the countdown reaches zero
            next_dir = dir;
        end else begin
            bounce_led = solid | (led_status_pkg::led_t'(1) << next_runner);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dir <= 1'b0;
        end else if (bounce_home) begin
            dir <= 1'b0;
        end else if (bounce_load) begin
            dir <= next_dir;
        end
    end

endmodule
